// File: cic_iq.f
+incdir+src
src/cic_pkg.sv
src/comb_mem_if.sv
src/cic_integrators.sv
src/comb_sequencer.sv
src/comb_mem_arbiter.sv
src/cic_iq_decimator.sv
verif/cic_iq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the I/Q CIC decimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f cic_iq.f --top-module cic_iq_tb \
	-Mdir obj_dir -o cic_iq_sim || { echo "build failed"; exit 1; }

result=$(./obj_dir/cic_iq_sim 2>&1)
echo "$result"

echo "$result" | grep -q "All checks passed" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

// File: verif/cic_iq_tb.sv
// ------------------------------
// testbench for the I/Q CIC decimator
// table of stimulus rows, integer
// CIC model, per-sample output checks
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

module cic_iq_tb;

	localparam int STAGES = `CIC_STAGES;
	localparam int DEC = `CIC_DECIMATION;
	localparam int IN_W = `CIC_IN_WIDTH;
	localparam int OUT_W = `CIC_OUT_WIDTH;
	localparam int SHIFT = `CIC_ACC_WIDTH - `CIC_OUT_WIDTH;
	localparam int KIND_CONST = 0;
	localparam int KIND_IMPULSE = 1;
	localparam int KIND_RANDOM = 2;
	localparam int MAX_ROWS = 8;

	typedef logic signed [`CIC_ACC_WIDTH-1:0] model_acc_t;

	logic clock = 1'b0;
	logic reset;
	logic in_strobe;
	logic signed [IN_W-1:0] in_data_i;
	logic signed [IN_W-1:0] in_data_q;
	logic out_strobe_i;
	logic out_strobe_q;
	logic signed [OUT_W-1:0] out_data_i;
	logic signed [OUT_W-1:0] out_data_q;

	// stimulus table with one array per column
	string row_name [MAX_ROWS];
	int row_kind [MAX_ROWS];
	int row_val_i [MAX_ROWS];
	int row_val_q [MAX_ROWS];
	int row_outputs [MAX_ROWS];
	bit row_reset [MAX_ROWS];
	int row_settle_i [MAX_ROWS];
	int row_settle_q [MAX_ROWS];
	int num_rows = 0;

	// model integrators and comb delays per channel
	model_acc_t integ_m [2][STAGES];
	model_acc_t prev_m [2][STAGES+1];
	int count_m;
	int out_index;

	// predicted outputs and their rows in arrival order
	int exp_i [$];
	int exp_q [$];
	int row_of_i [$];
	int row_of_q [$];

	int strobes_i = 0;
	int strobes_q = 0;
	int total_outputs = 0;
	int resets = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	integer seed = 32'h7e3f_ed26;

	cic_iq_decimator i_dut (
		.clock(clock),
		.reset(reset),
		.in_strobe(in_strobe),
		.in_data_i(in_data_i),
		.in_data_q(in_data_q),
		.out_strobe_i(out_strobe_i),
		.out_strobe_q(out_strobe_q),
		.out_data_i(out_data_i),
		.out_data_q(out_data_q)
	);

	always #5 clock = ~clock;

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (actual != expected)
			fail_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic add_row(input string name, input int kind, input int vi, input int vq,
		input int n, input bit rst, input int si, input int sq);
		row_name[num_rows] = name;
		row_kind[num_rows] = kind;
		row_val_i[num_rows] = vi;
		row_val_q[num_rows] = vq;
		row_outputs[num_rows] = n;
		row_reset[num_rows] = rst;
		row_settle_i[num_rows] = si;
		row_settle_q[num_rows] = sq;
		num_rows++;
	endtask

	// ------------------------------
	// behavioral CIC model
	// ------------------------------
	task automatic model_reset();
		for (int ch = 0; ch < 2; ch++)
		begin
			for (int k = 0; k < STAGES; k++)
				integ_m[ch][k] = '0;
			for (int k = 0; k <= STAGES; k++)
				prev_m[ch][k] = '0;
		end
		count_m = 0;
	endtask

	// keep the top output bits and add the first dropped bit
	function automatic int round_out(input model_acc_t c);
		int v;
		logic signed [OUT_W-1:0] o;
		v = int'(c >>> SHIFT) + int'(c[SHIFT-1]);
		o = OUT_W'(v);
		return o;
	endfunction

	task automatic model_sample(input int row, input int xi, input int xq);
		model_acc_t c;
		model_acc_t d;
		int x [2];
		int y [2];
		x[0] = xi;
		x[1] = xq;
		for (int ch = 0; ch < 2; ch++)
		begin
			// top stage first so each adds the old lower value
			for (int k = STAGES - 1; k > 0; k--)
				integ_m[ch][k] = integ_m[ch][k] + integ_m[ch][k-1];
			integ_m[ch][0] = integ_m[ch][0] + model_acc_t'(x[ch]);
		end
		count_m++;
		if (count_m == DEC)
		begin
			count_m = 0;
			for (int ch = 0; ch < 2; ch++)
			begin
				c = integ_m[ch][STAGES-1];
				for (int s = 1; s <= STAGES; s++)
				begin
					d = c - prev_m[ch][s];
					prev_m[ch][s] = c;
					c = d;
				end
				y[ch] = round_out(c);
			end
			// one output per channel per decimation group
			check_value({row_name[row], "_pending_i"}, 0, exp_i.size());
			check_value({row_name[row], "_pending_q"}, 0, exp_q.size());
			exp_i.push_back(y[0]);
			exp_q.push_back(y[1]);
			row_of_i.push_back(row);
			row_of_q.push_back(row);
			// unity DC gain once the comb window is full
			if ((row_kind[row] == KIND_CONST) && (out_index >= STAGES - 1))
			begin
				check_value({row_name[row], "_settled_i"}, row_settle_i[row], y[0]);
				check_value({row_name[row], "_settled_q"}, row_settle_q[row], y[1]);
			end
			if (row_kind[row] == KIND_IMPULSE)
				check_value({row_name[row], "_q_quiet"}, 0, y[1]);
			out_index++;
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic apply_reset();
		reset <= 1'b1;
		in_strobe <= 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		model_reset();
	endtask

	task automatic wait_drain();
		while ((exp_i.size() != 0) || (exp_q.size() != 0))
			@(posedge clock);
	endtask

	task automatic drive_row(input int row);
		logic signed [IN_W-1:0] si;
		logic signed [IN_W-1:0] sq;
		out_index = 0;
		for (int n = 0; n < row_outputs[row] * DEC; n++)
		begin
			case (row_kind[row])
				KIND_IMPULSE:
				begin
					si = (n == 0) ? IN_W'(row_val_i[row]) : '0;
					sq = (n == 0) ? IN_W'(row_val_q[row]) : '0;
				end
				KIND_RANDOM:
				begin
					si = IN_W'($random(seed));
					sq = IN_W'($random(seed));
				end
				default:
				begin
					si = IN_W'(row_val_i[row]);
					sq = IN_W'(row_val_q[row]);
				end
			endcase
			@(posedge clock);
			in_strobe <= 1'b1;
			in_data_i <= si;
			in_data_q <= sq;
			model_sample(row, int'(si), int'(sq));
			// one strobe every 4 cycles
			@(posedge clock);
			in_strobe <= 1'b0;
			repeat (2) @(posedge clock);
		end
	endtask

	// ------------------------------
	// output monitor sampled mid-cycle
	// ------------------------------
	always @(negedge clock)
	begin
		// Q first so the ordering test sees only earlier I strobes
		if (out_strobe_q === 1'b1)
		begin
			if (exp_q.size() == 0)
				fail_run("out_strobe_q pulsed with no decimated sample pending");
			else if (strobes_i <= strobes_q)
				fail_run("out_strobe_q came before its matching out_strobe_i");
			else
			begin
				check_value({row_name[row_of_q[0]], "_q"}, exp_q[0], int'(out_data_q));
				void'(exp_q.pop_front());
				void'(row_of_q.pop_front());
				strobes_q++;
			end
		end
		if (out_strobe_i === 1'b1)
		begin
			if (exp_i.size() == 0)
				fail_run("out_strobe_i pulsed with no decimated sample pending");
			else
			begin
				check_value({row_name[row_of_i[0]], "_i"}, exp_i[0], int'(out_data_i));
				void'(exp_i.pop_front());
				void'(row_of_i.pop_front());
				strobes_i++;
			end
		end
	end

	// run limit from the table length
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			fail_run($sformatf("timeout, no finish within %0d cycles", cycle_limit));
	end

	initial
	begin
		// name, kind, I, Q, outputs, reset first, settled I, settled Q
		add_row("dc_small", KIND_CONST, 1000, -2500, 6, 1'b0, 1000, -2500);
		add_row("dc_full_scale", KIND_CONST, 32767, -32768, 6, 1'b0, 32767, -32768);
		add_row("zero_flush", KIND_CONST, 0, 0, 5, 1'b0, 0, 0);
		add_row("impulse_i", KIND_IMPULSE, 12345, 0, 5, 1'b0, 0, 0);
		add_row("random_iq", KIND_RANDOM, 0, 0, 12, 1'b0, 0, 0);
		add_row("dc_after_random", KIND_CONST, -1, 1, 5, 1'b0, -1, 1);
		add_row("reset_then_dc", KIND_CONST, -7777, 4321, 6, 1'b1, -7777, 4321);
		for (int r = 0; r < num_rows; r++)
		begin
			total_outputs += row_outputs[r];
			if (row_reset[r])
				resets++;
		end
		// reset, memory clear, ~40 cycles per output, margin
		cycle_limit = 16 + 16 + total_outputs * 40 + resets * 32 + 200;
		in_data_i <= '0;
		in_data_q <= '0;
		apply_reset();
		for (int r = 0; r < num_rows; r++)
		begin
			if (row_reset[r])
			begin
				wait_drain();
				apply_reset();
			end
			drive_row(r);
		end
		wait_drain();
		// quiet window to catch stray strobes
		repeat (40) @(posedge clock);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/cic_iq_decimator.sv
// ------------------------------
// two-channel CIC decimator
// shared integrator front end,
// per-channel combs, one memory
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

module cic_iq_decimator
	import cic_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic in_strobe,
	input wire logic signed [`CIC_IN_WIDTH-1:0] in_data_i,
	input wire logic signed [`CIC_IN_WIDTH-1:0] in_data_q,
	output logic out_strobe_i,
	output logic out_strobe_q,
	output out_t out_data_i,
	output out_t out_data_q
);

	logic dec_strobe;
	acc_t integ_i;
	acc_t integ_q;

	// one memory port per channel
	comb_mem_if mem_bus_i ();
	comb_mem_if mem_bus_q ();

	cic_integrators i_integrators (
		.clock(clock),
		.reset(reset),
		.in_strobe(in_strobe),
		.in_data_i(in_data_i),
		.in_data_q(in_data_q),
		.dec_strobe(dec_strobe),
		.integ_i(integ_i),
		.integ_q(integ_q)
	);

	// I comb on the low half of the memory
	comb_sequencer #(.CHANNEL(1'b0)) i_seq_i (
		.clock(clock),
		.reset(reset),
		.dec_strobe(dec_strobe),
		.integ(integ_i),
		.mem(mem_bus_i.client),
		.out_strobe(out_strobe_i),
		.out_data(out_data_i)
	);

	comb_sequencer #(.CHANNEL(1'b1)) i_seq_q (
		.clock(clock),
		.reset(reset),
		.dec_strobe(dec_strobe),
		.integ(integ_q),
		.mem(mem_bus_q.client),
		.out_strobe(out_strobe_q),
		.out_data(out_data_q)
	);

	comb_mem_arbiter i_arbiter (
		.clock(clock),
		.reset(reset),
		.mem_i(mem_bus_i.arbiter),
		.mem_q(mem_bus_q.arbiter)
	);

endmodule

`default_nettype wire

// File: src/comb_mem_arbiter.sv
// ------------------------------
// comb memory and its arbiter
// clears the array after reset,
// then grants round-robin
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

module comb_mem_arbiter
	import cic_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	comb_mem_if.arbiter mem_i,
	comb_mem_if.arbiter mem_q
);

	localparam int ADDR_BITS = $bits(comb_addr_t);
	localparam int WORDS = 2 ** ADDR_BITS;

	acc_t mem [WORDS];

	// clear sweep after reset
	logic clearing;
	logic [ADDR_BITS-1:0] clear_count;

	logic grant_i;
	logic grant_q;
	// round-robin pointer, high when Q was served last
	logic last_q;

	logic wr_en;
	logic [ADDR_BITS-1:0] wr_addr;
	acc_t wr_data;
	logic [ADDR_BITS-1:0] rd_addr;
	acc_t rd_data;

	// ------------------------------
	// grant control
	// ------------------------------
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			clearing <= 1'b1;
			clear_count <= '0;
			grant_i <= 1'b0;
			grant_q <= 1'b0;
			last_q <= 1'b1;
		end
		else if (clearing)
		begin
			if (clear_count == ADDR_BITS'(WORDS - 1))
				clearing <= 1'b0;
			clear_count <= clear_count + 1'b1;
		end
		// held while the owner keeps req, one idle cycle on release
		else if (grant_i)
		begin
			if (!mem_i.req)
				grant_i <= 1'b0;
		end
		else if (grant_q)
		begin
			if (!mem_q.req)
				grant_q <= 1'b0;
		end
		else if (mem_i.req && (last_q || !mem_q.req))
		begin
			grant_i <= 1'b1;
			last_q <= 1'b0;
		end
		else if (mem_q.req)
		begin
			grant_q <= 1'b1;
			last_q <= 1'b1;
		end
	end

	// owner's ports to the array, clear sweep wins
	always_comb
	begin
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		if (clearing)
		begin
			wr_en = 1'b1;
			wr_addr = clear_count;
		end
		else if (grant_i)
		begin
			wr_en = mem_i.we;
			wr_addr = mem_i.waddr;
			wr_data = mem_i.wdata;
		end
		else if (grant_q)
		begin
			wr_en = mem_q.we;
			wr_addr = mem_q.waddr;
			wr_data = mem_q.wdata;
		end
		rd_addr = grant_q ? mem_q.raddr : mem_i.raddr;
	end

	// ------------------------------
	// array, registered read
	// ------------------------------
	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

	assign mem_i.grant = grant_i;
	assign mem_q.grant = grant_q;

	// only the owner uses the read data
	assign mem_i.rdata = rd_data;
	assign mem_q.rdata = rd_data;

endmodule

`default_nettype wire

// File: src/comb_sequencer.sv
// ------------------------------
// comb sequencer, one channel
// runs all comb stages through
// the shared memory and rounds
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

module comb_sequencer
	import cic_pkg::*;
#(
	parameter bit CHANNEL = 1'b0
)
(
	input wire logic clock,
	input wire logic reset,
	input wire logic dec_strobe,
	input wire acc_t integ,
	comb_mem_if.client mem,
	output logic out_strobe,
	output out_t out_data
);

	localparam logic [`CIC_STAGE_BITS-1:0] LAST_STAGE = `CIC_STAGE_BITS'(`CIC_STAGES);

	seq_state_t state;
	logic [`CIC_STAGE_BITS-1:0] stage;

	// decimated word and the comb input of the current stage
	acc_t word;
	acc_t t;

	// rounding taps on the final comb output
	logic [`CIC_OUT_WIDTH-1:0] top_bits;
	logic round_bit;

	// address in this channel's half of the memory
	function automatic comb_addr_t word_addr(input word_kind_t kind,
		input logic [`CIC_STAGE_BITS-1:0] stage_sel);
		comb_addr_t addr;
		addr.channel = CHANNEL;
		addr.kind = kind;
		addr.stage = stage_sel;
		return addr;
	endfunction

	// ------------------------------
	// memory port, decoded from state
	// ------------------------------
	always_comb
	begin
		mem.req = (state != SEQ_IDLE) && (state != SEQ_FINISH);
		mem.we = 1'b0;
		mem.waddr = word_addr(WORD_COMB, '0);
		mem.wdata = word;
		mem.raddr = word_addr(WORD_COMB, '0);
		case (state)
			// comb[0] = integ, written in the grant cycle
			SEQ_REQUEST:
				mem.we = mem.grant;
			// fetch prev[s] while t takes comb[s-1]
			SEQ_READ_DELAY:
				mem.raddr = word_addr(WORD_PREV, stage);
			// comb[s] = t - prev[s]
			SEQ_WRITE_COMB:
			begin
				mem.we = 1'b1;
				mem.waddr = word_addr(WORD_COMB, stage);
				mem.wdata = t - mem.rdata;
			end
			// prev[s] = t, and comb[s] is the next stage's input
			SEQ_WRITE_DELAY:
			begin
				mem.we = 1'b1;
				mem.waddr = word_addr(WORD_PREV, stage);
				mem.wdata = t;
				mem.raddr = word_addr(WORD_COMB, stage);
			end
			// LOAD reads comb[0] through the default
			default:
				mem.we = 1'b0;
		endcase
	end

	// ------------------------------
	// pass control
	// ------------------------------
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			stage <= '0;
			out_strobe <= 1'b0;
		end
		else
		begin
			out_strobe <= (state == SEQ_FINISH);
			case (state)
				SEQ_IDLE:
					if (dec_strobe)
						state <= SEQ_REQUEST;
				SEQ_REQUEST:
					if (mem.grant)
					begin
						stage <= `CIC_STAGE_BITS'(1);
						state <= SEQ_LOAD;
					end
				SEQ_LOAD:
					state <= SEQ_READ_DELAY;
				SEQ_READ_DELAY:
					state <= SEQ_WRITE_COMB;
				SEQ_WRITE_COMB:
					state <= SEQ_WRITE_DELAY;
				SEQ_WRITE_DELAY:
					if (stage == LAST_STAGE)
						state <= SEQ_FINISH;
					else
					begin
						stage <= stage + 1'b1;
						state <= SEQ_READ_DELAY;
					end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if ((state == SEQ_IDLE) && dec_strobe)
			word <= integ;
		if (state == SEQ_READ_DELAY)
			t <= mem.rdata;
		if (state == SEQ_FINISH)
			out_data <= top_bits + {{(`CIC_OUT_WIDTH-1){1'b0}}, round_bit};
	end

	// round half up on the last comb output
	assign top_bits = mem.rdata[`CIC_ACC_WIDTH-1 -: `CIC_OUT_WIDTH];
	assign round_bit = mem.rdata[`CIC_ACC_WIDTH-1-`CIC_OUT_WIDTH];

endmodule

`default_nettype wire

// File: src/cic_integrators.sv
// ------------------------------
// CIC integrator section
// full-rate I/Q integrator chains
// and the decimation counter
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

module cic_integrators
	import cic_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic in_strobe,
	input wire logic signed [`CIC_IN_WIDTH-1:0] in_data_i,
	input wire logic signed [`CIC_IN_WIDTH-1:0] in_data_q,
	output logic dec_strobe,
	output acc_t integ_i,
	output acc_t integ_q
);

	localparam int COUNT_BITS = $clog2(`CIC_DECIMATION);
	localparam logic [COUNT_BITS-1:0] LAST_COUNT = COUNT_BITS'(`CIC_DECIMATION - 1);

	logic [COUNT_BITS-1:0] sample_count;

	// one accumulator per stage and channel
	acc_t acc_i [`CIC_STAGES];
	acc_t acc_q [`CIC_STAGES];

	// sign extended inputs
	acc_t ext_i;
	acc_t ext_q;

	assign ext_i = acc_t'(in_data_i);
	assign ext_q = acc_t'(in_data_q);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sample_count <= '0;
			dec_strobe <= 1'b0;
			for (int k = 0; k < `CIC_STAGES; k++)
			begin
				acc_i[k] <= '0;
				acc_q[k] <= '0;
			end
		end
		else
		begin
			dec_strobe <= 1'b0;
			if (in_strobe)
			begin
				// pulse on every DECIMATION-th sample
				if (sample_count == LAST_COUNT)
				begin
					sample_count <= '0;
					dec_strobe <= 1'b1;
				end
				else
					sample_count <= sample_count + 1'b1;

				// cascade, each stage adds the previous stage's old value
				acc_i[0] <= acc_i[0] + ext_i;
				acc_q[0] <= acc_q[0] + ext_q;
				for (int k = 1; k < `CIC_STAGES; k++)
				begin
					acc_i[k] <= acc_i[k] + acc_i[k-1];
					acc_q[k] <= acc_q[k] + acc_q[k-1];
				end
			end
		end
	end

	// last stage feeds the combs
	assign integ_i = acc_i[`CIC_STAGES-1];
	assign integ_q = acc_q[`CIC_STAGES-1];

endmodule

`default_nettype wire

// File: src/comb_mem_if.sv
// ------------------------------
// comb memory port
// one client's request/grant and
// its write and read channels
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "cic_config.svh"

interface comb_mem_if;

	// held high for a whole pass
	logic req;
	logic grant;

	// write side, acts only under grant
	logic we;
	cic_pkg::comb_addr_t waddr;
	cic_pkg::acc_t wdata;

	// registered read, data one cycle after raddr
	cic_pkg::comb_addr_t raddr;
	cic_pkg::acc_t rdata;

	modport client (
		output req, we, waddr, wdata, raddr,
		input grant, rdata
	);

	modport arbiter (
		input req, we, waddr, wdata, raddr,
		output grant, rdata
	);

endinterface

`default_nettype wire

// File: src/cic_pkg.sv
// ------------------------------
// CIC decimator types
// datapath words, comb memory
// address layout, FSM encoding
// ------------------------------

`default_nettype none

`include "cic_config.svh"

package cic_pkg;

	// full precision accumulator, wraps modulo 2**width
	typedef logic signed [`CIC_ACC_WIDTH-1:0] acc_t;

	// rounded output sample
	typedef logic signed [`CIC_OUT_WIDTH-1:0] out_t;

	// comb output or previous-input delay word
	typedef enum logic {
		WORD_COMB = 1'b0,
		WORD_PREV = 1'b1
	} word_kind_t;

	// comb memory address, 16 words
	// channel selects the I or Q half
	typedef struct packed {
		logic channel;
		word_kind_t kind;
		logic [`CIC_STAGE_BITS-1:0] stage;
	} comb_addr_t;

	// comb sequencer states
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_REQUEST,
		SEQ_LOAD,
		SEQ_READ_DELAY,
		SEQ_WRITE_COMB,
		SEQ_WRITE_DELAY,
		SEQ_FINISH
	} seq_state_t;

endpackage

`default_nettype wire

// File: src/cic_config.svh
// ------------------------------
// CIC decimator configuration
// stage count, rate and word widths
// for the I/Q decimator datapath
// ------------------------------

`ifndef CIC_CONFIG_SVH
`define CIC_CONFIG_SVH

// integrator and comb stages, differential delay fixed at 1
`define CIC_STAGES 3

// fixed decimation ratio
`define CIC_DECIMATION 8

// sample widths at the ports
`define CIC_IN_WIDTH 16
`define CIC_OUT_WIDTH 16

// growth is stages * log2(decimation)
`define CIC_GROWTH (`CIC_STAGES * $clog2(`CIC_DECIMATION))
`define CIC_ACC_WIDTH (`CIC_IN_WIDTH + `CIC_GROWTH)

// stage index must hold 0 .. CIC_STAGES
`define CIC_STAGE_BITS 2

`endif
